/* hw/riscv_pkg.sv */
//====================
// Scalar-side vector types: vtype CSR layout,
// SEW encoding and the slice's operation codes
//====================
package riscv_pkg;

    // SEW field of vtype
    typedef logic [2:0] riscv_v_vsew_t;

    // SEW codes, 8 to 128 bits
    localparam riscv_v_vsew_t RISCV_V_VSEW_8   = 3'd0;
    localparam riscv_v_vsew_t RISCV_V_VSEW_16  = 3'd1;
    localparam riscv_v_vsew_t RISCV_V_VSEW_32  = 3'd2;
    localparam riscv_v_vsew_t RISCV_V_VSEW_64  = 3'd3;
    localparam riscv_v_vsew_t RISCV_V_VSEW_128 = 3'd4;

    // vtype CSR for XLEN 32, vill in the top bit
    typedef struct packed {
        logic          vill;
        logic [22:0]   reserved;
        logic          vma;
        logic          vta;
        riscv_v_vsew_t vsew;
        logic [2:0]    vlmul;
    } riscv_vtype_t;

    // Operations executed by the slice
    typedef enum logic [1:0] {
        RISCV_V_OP_ADD    = 2'd0,
        RISCV_V_OP_SUB    = 2'd1,
        RISCV_V_OP_CMP_EQ = 2'd2
    } riscv_v_op_e;

endpackage : riscv_pkg

/* hw/riscv_v_pkg.sv */
//====================
// Vector-side constants and widths, the osize
// encoding and the pipeline stage structs
//====================
package riscv_v_pkg;

    localparam int RISCV_V_NUM_BYTES_DATA          = 16;
    localparam int RISCV_V_DATA_WIDTH              = 8 * RISCV_V_NUM_BYTES_DATA;
    localparam int RISCV_V_NUM_ELEMENTS_REG        = 16;
    localparam int RISCV_V_NUM_VALID_OSIZES        = 5;
    // Bytes holding a mask register result, one bit per element
    localparam int RISCV_V_NUM_BYTES_ALLOCATE_MASK = RISCV_V_NUM_ELEMENTS_REG / 8;

    typedef logic [RISCV_V_DATA_WIDTH-1:0]       riscv_v_data_t;
    typedef logic [RISCV_V_NUM_ELEMENTS_REG-1:0] riscv_v_mask_t;
    typedef logic [RISCV_V_NUM_BYTES_DATA-1:0]   riscv_v_valid_data_t;
    // Bit i links the carry of byte i into byte i+1
    typedef logic [RISCV_V_NUM_BYTES_DATA-1:0]   riscv_v_merge_data_t;
    // Holds 0 to 16
    typedef logic [4:0]                          riscv_v_vl_t;
    typedef logic [3:0]                          riscv_v_vstart_t;
    // One-hot, bit k set for 8 << k bit elements
    typedef logic [RISCV_V_NUM_VALID_OSIZES-1:0] osize_vector_t;

    typedef enum riscv_pkg::riscv_v_vsew_t {
        OSIZE_8   = riscv_pkg::RISCV_V_VSEW_8,
        OSIZE_16  = riscv_pkg::RISCV_V_VSEW_16,
        OSIZE_32  = riscv_pkg::RISCV_V_VSEW_32,
        OSIZE_64  = riscv_pkg::RISCV_V_VSEW_64,
        OSIZE_128 = riscv_pkg::RISCV_V_VSEW_128
    } riscv_v_osize_e;

    // Operand with its byte qualifiers
    typedef struct packed {
        riscv_v_data_t       data;
        riscv_v_valid_data_t valid;
        riscv_v_merge_data_t merge;
    } riscv_v_alu_data_t;

    // Complete operation from the issuing side
    typedef struct packed {
        riscv_pkg::riscv_v_op_e  op;
        riscv_pkg::riscv_vtype_t vtype;
        riscv_v_vl_t             vl;
        riscv_v_vstart_t         vstart;
        logic                    use_mask;
        riscv_v_mask_t           mask;
        riscv_v_data_t           vs1;
        riscv_v_data_t           vs2;
        riscv_v_data_t           vd_old;
    } riscv_v_issue_t;

    // Decode to ALU
    typedef struct packed {
        riscv_pkg::riscv_v_op_e op;
        riscv_v_alu_data_t      srca_alu;
        riscv_v_alu_data_t      srcb_alu;
        riscv_v_mask_t          mask_osize_sel;
        riscv_v_mask_t          mask_result_valid;
        riscv_v_mask_t          mask_merge_qual;
        riscv_v_data_t          vd_old;
        osize_vector_t          dst_osize_vector;
    } riscv_v_alu_in_t;

    // ALU to writeback, eq holds one equality bit per element
    typedef struct packed {
        riscv_pkg::riscv_v_op_e op;
        riscv_v_data_t          data;
        riscv_v_valid_data_t    valid;
        riscv_v_mask_t          eq;
        riscv_v_mask_t          mask_result_valid;
        riscv_v_mask_t          mask_merge_qual;
        riscv_v_data_t          vd_old;
    } riscv_v_wb_in_t;

    typedef struct packed {
        riscv_v_data_t data;
        logic          is_mask;
    } riscv_v_wb_t;

endpackage : riscv_v_pkg

/* hw/riscv_v_decode_element.sv */
//====================
// Vector decode element: byte valid and merge bits,
// element mask selection and mask result qualifiers
//====================
`timescale 1ns/10ps

module riscv_v_decode_element (
    input  riscv_v_pkg::riscv_v_data_t       srca,
    input  riscv_v_pkg::riscv_v_data_t       srcb,
    input  riscv_pkg::riscv_vtype_t          vtype,
    input  riscv_v_pkg::riscv_v_vl_t         vl,
    input  riscv_v_pkg::riscv_v_vstart_t     vstart,
    input  logic                             is_mask,
    input  logic                             is_compare,
    input  logic                             use_mask,
    input  riscv_v_pkg::riscv_v_mask_t       mask,
    input  riscv_v_pkg::riscv_v_mask_t       mask_merge,
    output riscv_v_pkg::riscv_v_alu_data_t   srca_alu,
    output riscv_v_pkg::riscv_v_alu_data_t   srcb_alu,
    output riscv_v_pkg::riscv_v_mask_t       mask_osize_sel,
    output riscv_v_pkg::riscv_v_mask_t       mask_merge_qual,
    output riscv_v_pkg::riscv_v_mask_t       mask_result_valid,
    output riscv_v_pkg::osize_vector_t       dst_osize_vector,
    output riscv_v_pkg::osize_vector_t       is_greater_osize_vector,
    output riscv_v_pkg::osize_vector_t       is_less_osize_vector
);
    import riscv_pkg::*;
    import riscv_v_pkg::*;

    riscv_v_osize_e      dst_osize;
    // Element index inside [vstart, vl)
    riscv_v_mask_t       len_start_vec;
    riscv_v_valid_data_t valid_sel;
    riscv_v_valid_data_t mask_valid;
    riscv_v_valid_data_t is_mask_valid;
    riscv_v_merge_data_t merge_sel;

    assign dst_osize = riscv_v_osize_e'(vtype.vsew);

    // Reserved vsew codes leave the vector all zero
    assign dst_osize_vector = {
        dst_osize == OSIZE_128,
        dst_osize == OSIZE_64,
        dst_osize == OSIZE_32,
        dst_osize == OSIZE_16,
        dst_osize == OSIZE_8
    };

    // Bit k set when the element is at least 8 << k bits
    assign is_greater_osize_vector[0] = 1'b1;
    for (genvar k = 1; k < RISCV_V_NUM_VALID_OSIZES; k++) begin : gen_greater
        assign is_greater_osize_vector[k] = |dst_osize_vector[RISCV_V_NUM_VALID_OSIZES-1:k];
    end

    // Bit k set when the element is at most 8 << k bits
    assign is_less_osize_vector[RISCV_V_NUM_VALID_OSIZES-1] = 1'b1;
    for (genvar k = 0; k < RISCV_V_NUM_VALID_OSIZES - 1; k++) begin : gen_less
        assign is_less_osize_vector[k] = ~is_greater_osize_vector[k+1];
    end

    for (genvar e = 0; e < RISCV_V_NUM_ELEMENTS_REG; e++) begin : gen_elem
        // Largest osize that still holds element e in the register
        localparam int OSIZE_LIMIT = (RISCV_V_NUM_VALID_OSIZES - 1) - $clog2(e + 1);

        assign len_start_vec[e] = (vl > riscv_v_vl_t'(e)) & (vstart <= riscv_v_vstart_t'(e));

        // Compare results also need the mask bit and an element that exists
        assign mask_result_valid[e] = len_start_vec[e] &
            ~(is_compare & ((use_mask & ~mask[e]) | ~is_less_osize_vector[OSIZE_LIMIT]));
    end

    // Spread element state over the bytes of each element
    always_comb begin
        valid_sel      = '0;
        mask_osize_sel = '0;
        merge_sel      = '0;
        for (int k = 0; k < RISCV_V_NUM_VALID_OSIZES; k++) begin
            for (int b = 0; b < RISCV_V_NUM_BYTES_DATA; b++) begin
                if (dst_osize_vector[k]) begin
                    valid_sel[b]      = len_start_vec[b >> k];
                    mask_osize_sel[b] = mask[b >> k];
                    // Top byte of an element never passes its carry on
                    merge_sel[b]      = ((b + 1) % (1 << k)) != 0;
                end
            end
        end
    end

    assign mask_valid = {RISCV_V_NUM_BYTES_DATA{~use_mask}} | mask_osize_sel;

    // Mask destinations only write the low bytes
    assign is_mask_valid = {
        {(RISCV_V_NUM_BYTES_DATA - RISCV_V_NUM_BYTES_ALLOCATE_MASK){~is_mask}},
        {RISCV_V_NUM_BYTES_ALLOCATE_MASK{1'b1}}
    };

    assign srca_alu = '{
        data:  srca,
        valid: valid_sel & mask_valid & is_mask_valid,
        merge: merge_sel
    };

    assign srcb_alu = '{
        data:  srcb,
        valid: valid_sel & mask_valid,
        merge: merge_sel
    };

    // Old mask bits survive only where no result bit lands
    assign mask_merge_qual = mask_merge & {RISCV_V_NUM_ELEMENTS_REG{is_mask}} & ~mask_result_valid;

endmodule : riscv_v_decode_element

/* hw/riscv_v_decode_stage.sv */
//====================
// Decode stage: decode element on the issued
// operation, registered into the ALU struct
//====================
`timescale 1ns/10ps

module riscv_v_decode_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issue_valid,
    input  riscv_v_pkg::riscv_v_issue_t   issue,
    output logic                          alu_valid,
    output riscv_v_pkg::riscv_v_alu_in_t  alu_in
);
    import riscv_pkg::*;
    import riscv_v_pkg::*;

    logic              is_cmp;
    riscv_v_alu_data_t srca_alu;
    riscv_v_alu_data_t srcb_alu;
    riscv_v_mask_t     mask_osize_sel;
    riscv_v_mask_t     mask_merge_qual;
    riscv_v_mask_t     mask_result_valid;
    osize_vector_t     dst_osize_vector;

    // Compare writes a mask register
    assign is_cmp = (issue.op == RISCV_V_OP_CMP_EQ);

    // srca is vs2 so that subtract gives vs2 - vs1
    riscv_v_decode_element riscv_v_decode_element_i (
        .srca                    (issue.vs2),
        .srcb                    (issue.vs1),
        .vtype                   (issue.vtype),
        .vl                      (issue.vl),
        .vstart                  (issue.vstart),
        .is_mask                 (is_cmp),
        .is_compare              (is_cmp),
        .use_mask                (issue.use_mask),
        .mask                    (issue.mask),
        .mask_merge              (issue.vd_old[RISCV_V_NUM_ELEMENTS_REG-1:0]),
        .srca_alu                (srca_alu),
        .srcb_alu                (srcb_alu),
        .mask_osize_sel          (mask_osize_sel),
        .mask_merge_qual         (mask_merge_qual),
        .mask_result_valid       (mask_result_valid),
        .dst_osize_vector        (dst_osize_vector),
        .is_greater_osize_vector (),
        .is_less_osize_vector    ()
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            alu_in <= '{
                op:                issue.op,
                srca_alu:          srca_alu,
                srcb_alu:          srcb_alu,
                mask_osize_sel:    mask_osize_sel,
                mask_result_valid: mask_result_valid,
                mask_merge_qual:   mask_merge_qual,
                vd_old:            issue.vd_old,
                dst_osize_vector:  dst_osize_vector
            };
        end
    end

endmodule : riscv_v_decode_stage

/* hw/riscv_v_alu_stage.sv */
//====================
// ALU stage: byte-lane add and subtract with
// merge-linked carries, element equality compare
//====================
`timescale 1ns/10ps

module riscv_v_alu_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          alu_valid,
    input  riscv_v_pkg::riscv_v_alu_in_t  alu_in,
    output logic                          wb_in_valid,
    output riscv_v_pkg::riscv_v_wb_in_t   wb_in
);
    import riscv_pkg::*;
    import riscv_v_pkg::*;

    logic                            is_sub;
    riscv_v_data_t                   srcb_op;
    riscv_v_data_t                   sum;
    // Bit b set when byte b takes the carry of byte b-1
    riscv_v_merge_data_t             link_in;
    logic [RISCV_V_NUM_BYTES_DATA:0] carry;
    riscv_v_valid_data_t             carry_in;
    riscv_v_valid_data_t             byte_eq;
    riscv_v_mask_t                   eq_osize [RISCV_V_NUM_VALID_OSIZES];
    riscv_v_mask_t                   elem_eq;

    assign is_sub  = (alu_in.op == RISCV_V_OP_SUB);
    assign srcb_op = alu_in.srcb_alu.data ^ {RISCV_V_DATA_WIDTH{is_sub}};
    assign link_in = {alu_in.srca_alu.merge[RISCV_V_NUM_BYTES_DATA-2:0], 1'b0};

    // Subtract starts each element with a carry of one
    always_comb begin
        carry = '0;
        for (int b = 0; b < RISCV_V_NUM_BYTES_DATA; b++) begin
            carry_in[b] = link_in[b] ? carry[b] : is_sub;
            {carry[b+1], sum[b*8 +: 8]} = {1'b0, alu_in.srca_alu.data[b*8 +: 8]} +
                                          {1'b0, srcb_op[b*8 +: 8]} + 9'(carry_in[b]);
        end
    end

    for (genvar b = 0; b < RISCV_V_NUM_BYTES_DATA; b++) begin : gen_byte_eq
        assign byte_eq[b] = alu_in.srca_alu.data[b*8 +: 8] == alu_in.srcb_alu.data[b*8 +: 8];
    end

    // Element equality per width, upper elements absent for wide SEW
    for (genvar k = 0; k < RISCV_V_NUM_VALID_OSIZES; k++) begin : gen_eq_osize
        localparam int ELEM_BYTES = 1 << k;
        localparam int NUM_ELEMS  = RISCV_V_NUM_BYTES_DATA / ELEM_BYTES;

        for (genvar e = 0; e < NUM_ELEMS; e++) begin : gen_eq_elem
            assign eq_osize[k][e] = &byte_eq[e*ELEM_BYTES +: ELEM_BYTES];
        end
        if (NUM_ELEMS < RISCV_V_NUM_ELEMENTS_REG) begin : gen_eq_pad
            assign eq_osize[k][RISCV_V_NUM_ELEMENTS_REG-1:NUM_ELEMS] = '0;
        end
    end

    always_comb begin
        elem_eq = '0;
        for (int k = 0; k < RISCV_V_NUM_VALID_OSIZES; k++) begin
            elem_eq |= eq_osize[k] & {RISCV_V_NUM_ELEMENTS_REG{alu_in.dst_osize_vector[k]}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_in_valid <= 1'b0;
        end else begin
            wb_in_valid <= alu_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            wb_in <= '{
                op:                alu_in.op,
                data:              sum,
                valid:             alu_in.srca_alu.valid,
                eq:                elem_eq,
                mask_result_valid: alu_in.mask_result_valid,
                mask_merge_qual:   alu_in.mask_merge_qual,
                vd_old:            alu_in.vd_old
            };
        end
    end

endmodule : riscv_v_alu_stage

/* hw/riscv_v_writeback_stage.sv */
//====================
// Writeback stage: byte merge into the old
// destination and mask register results
//====================
`timescale 1ns/10ps

module riscv_v_writeback_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wb_in_valid,
    input  riscv_v_pkg::riscv_v_wb_in_t  wb_in,
    output logic                         wb_valid,
    output riscv_v_pkg::riscv_v_wb_t     wb
);
    import riscv_pkg::*;
    import riscv_v_pkg::*;

    logic          is_cmp;
    riscv_v_data_t byte_merged;
    riscv_v_mask_t mask_bits;
    riscv_v_data_t result;

    assign is_cmp = (wb_in.op == RISCV_V_OP_CMP_EQ);

    // Inactive bytes keep the old destination
    always_comb begin
        for (int b = 0; b < RISCV_V_NUM_BYTES_DATA; b++) begin
            byte_merged[b*8 +: 8] = wb_in.valid[b] ? wb_in.data[b*8 +: 8]
                                                   : wb_in.vd_old[b*8 +: 8];
        end
    end

    // New bit where the result is valid, old bit where qualified, else zero
    assign mask_bits = (wb_in.eq & wb_in.mask_result_valid) |
                       (wb_in.vd_old[RISCV_V_NUM_ELEMENTS_REG-1:0] & wb_in.mask_merge_qual);

    assign result = is_cmp ?
        {wb_in.vd_old[RISCV_V_DATA_WIDTH-1:RISCV_V_NUM_ELEMENTS_REG], mask_bits} :
        byte_merged;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= wb_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_in_valid) begin
            wb <= '{data: result, is_mask: is_cmp};
        end
    end

endmodule : riscv_v_writeback_stage

/* hw/riscv_v_top.sv */
//====================
// Vector execution slice top: decode, ALU and
// writeback stages in a three cycle chain
//====================
`timescale 1ns/10ps

module riscv_v_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         issue_valid,
    input  riscv_v_pkg::riscv_v_issue_t  issue,
    output logic                         wb_valid,
    output riscv_v_pkg::riscv_v_wb_t     wb
);
    import riscv_v_pkg::*;

    logic            alu_valid;
    riscv_v_alu_in_t alu_in;
    logic            wb_in_valid;
    riscv_v_wb_in_t  wb_in;

    riscv_v_decode_stage riscv_v_decode_stage_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .alu_valid   (alu_valid),
        .alu_in      (alu_in)
    );

    riscv_v_alu_stage riscv_v_alu_stage_i (
        .clk         (clk),
        .rst         (rst),
        .alu_valid   (alu_valid),
        .alu_in      (alu_in),
        .wb_in_valid (wb_in_valid),
        .wb_in       (wb_in)
    );

    riscv_v_writeback_stage riscv_v_writeback_stage_i (
        .clk         (clk),
        .rst         (rst),
        .wb_in_valid (wb_in_valid),
        .wb_in       (wb_in),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

endmodule : riscv_v_top

/* tests/riscv_v_tb.sv */
//====================
// Testbench for the vector execution slice:
// clock, reset, LFSR stimulus, reference model,
// writeback monitor and directed tests
//====================
`timescale 1ns/10ps

module riscv_v_tb;
    import riscv_pkg::*;
    import riscv_v_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 5;
    localparam int NUM_TESTS    = 6;
    localparam int NUM_OPS      = 48;
    // Directed tests spend at most two cycles per operation
    localparam int CYCLE_LIMIT  = 2 * (2 * NUM_OPS) + RESET_CYCLES + NUM_TESTS * DRAIN_CYCLES;

    logic           clk;
    logic           rst;
    logic           issue_valid;
    riscv_v_issue_t issue;
    logic           wb_valid;
    riscv_v_wb_t    wb;

    logic [31:0]    lfsr_state = 32'h4060_929f;
    int             cycles = 0;
    riscv_v_wb_t    exp_q [$];
    int             due_q [$];

    riscv_v_top riscv_v_top_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input riscv_v_data_t exp, input riscv_v_data_t act);
        $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
        stop_on_failure();
    endtask

    task automatic plain_error(input string msg);
        $display("%s", msg);
        stop_on_failure();
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic riscv_v_data_t rand_bits(input int n);
        riscv_v_data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[RISCV_V_DATA_WIDTH-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // All ones over the bits of one element
    function automatic riscv_v_data_t elem_ones(input riscv_v_vsew_t sew);
        return (sew == RISCV_V_VSEW_128) ? '1 : ((128'd1 << (8 << sew)) - 128'd1);
    endfunction

    // Reference result from the element rules
    function automatic riscv_v_wb_t expected_wb(input riscv_v_issue_t op);
        int            nelem;
        int            sh;
        logic          wr;
        riscv_v_data_t emask;
        riscv_v_data_t a;
        riscv_v_data_t b;
        riscv_v_data_t r;
        riscv_v_wb_t   res;
        nelem = 16 >> op.vtype.vsew;
        emask = elem_ones(op.vtype.vsew);
        res.data = op.vd_old;
        res.is_mask = (op.op == RISCV_V_OP_CMP_EQ);
        for (int e = 0; e < nelem; e++) begin
            sh = e * (8 << op.vtype.vsew);
            a  = (op.vs2 >> sh) & emask;
            b  = (op.vs1 >> sh) & emask;
            wr = (e >= op.vstart) && (e < op.vl) && (!op.use_mask || op.mask[e]);
            if (res.is_mask) begin
                res.data[e] = wr ? (a == b) : op.vd_old[e];
            end else if (wr) begin
                r = ((op.op == RISCV_V_OP_SUB) ? a - b : a + b) & emask;
                res.data = (res.data & ~(emask << sh)) | (r << sh);
            end
        end
        return res;
    endfunction

    function automatic riscv_v_issue_t random_op(input riscv_v_op_e code, input riscv_v_vsew_t sew);
        riscv_v_issue_t op;
        op            = '0;
        op.op         = code;
        op.vtype.vsew = sew;
        op.vl         = 5'd16;
        op.mask       = riscv_v_mask_t'(rand_bits(16));
        op.vs1        = rand_bits(128);
        op.vs2        = rand_bits(128);
        op.vd_old     = rand_bits(128);
        return op;
    endfunction

    // Copy randomly chosen vs2 elements into vs1
    function automatic riscv_v_issue_t force_equal(input riscv_v_issue_t op);
        int            sh;
        riscv_v_data_t emask;
        emask = elem_ones(op.vtype.vsew);
        for (int e = 0; e < (16 >> op.vtype.vsew); e++) begin
            sh = e * (8 << op.vtype.vsew);
            if (rand_bits(1) != 0) begin
                op.vs1 = (op.vs1 & ~(emask << sh)) | (op.vs2 & (emask << sh));
            end
        end
        return op;
    endfunction

    task automatic issue_op(input riscv_v_issue_t op);
        @(negedge clk);
        issue_valid = 1'b1;
        issue       = op;
        exp_q.push_back(expected_wb(op));
        // Sampled on the next rising edge, result after the third one
        due_q.push_back(cycles + 3);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic add_every_sew();
        for (int k = 0; k < 5; k++) begin
            issue_op(random_op(RISCV_V_OP_ADD, riscv_v_vsew_t'(k)));
            idle_cycle();
        end
        wait_drained();
    endtask

    task automatic sub_every_sew();
        for (int k = 0; k < 5; k++) begin
            issue_op(random_op(RISCV_V_OP_SUB, riscv_v_vsew_t'(k)));
            idle_cycle();
        end
        wait_drained();
    endtask

    task automatic vl_vstart_limits();
        riscv_v_issue_t op;
        for (int i = 0; i < 10; i++) begin
            op        = random_op((i % 2) ? RISCV_V_OP_SUB : RISCV_V_OP_ADD, riscv_v_vsew_t'(i / 2));
            op.vl     = riscv_v_vl_t'(rand_bits(5) % 17);
            op.vstart = riscv_v_vstart_t'(rand_bits(4));
            issue_op(op);
            idle_cycle();
        end
        wait_drained();
    endtask

    task automatic masked_add();
        riscv_v_issue_t op;
        for (int i = 0; i < 10; i++) begin
            op          = random_op(RISCV_V_OP_ADD, riscv_v_vsew_t'(i / 2));
            op.use_mask = (i % 2) == 1;
            issue_op(op);
            idle_cycle();
        end
        wait_drained();
    endtask

    task automatic compare_equal();
        riscv_v_issue_t op;
        for (int i = 0; i < 10; i++) begin
            op          = force_equal(random_op(RISCV_V_OP_CMP_EQ, riscv_v_vsew_t'(i / 2)));
            op.use_mask = (i % 2) == 1;
            // Second pass also limits the element range
            if (i % 4 >= 2) begin
                op.vl     = riscv_v_vl_t'(rand_bits(5) % 17);
                op.vstart = riscv_v_vstart_t'(rand_bits(3));
            end
            issue_op(op);
            idle_cycle();
        end
        wait_drained();
    endtask

    task automatic back_to_back();
        riscv_v_issue_t op;
        int             sel;
        for (int i = 0; i < 8; i++) begin
            sel = int'(rand_bits(2) % 3);
            op  = random_op(RISCV_V_OP_ADD, riscv_v_vsew_t'(rand_bits(3) % 5));
            if (sel == 1) begin
                op.op = RISCV_V_OP_SUB;
            end else if (sel == 2) begin
                op = force_equal(op);
                op.op = RISCV_V_OP_CMP_EQ;
            end
            op.use_mask = rand_bits(1) != 0;
            issue_op(op);
        end
        idle_cycle();
        wait_drained();
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            plain_error($sformatf("Timeout after %0d cycles", cycles));
        end
    end

    // Writeback monitor, outputs are stable at the falling edge
    // Registers hold no value before the first rising edge
    always @(negedge clk) begin
        if (cycles != 0 && wb_valid !== 1'b0) begin
            assert (due_q.size() != 0)
                else plain_error("wb_valid is high with no operation in flight");
            assert (due_q[0] == cycles)
                else plain_error($sformatf("wb_valid at cycle %0d, expected at cycle %0d",
                                           cycles, due_q[0]));
            assert (wb.data === exp_q[0].data)
                else value_error("wb.data", exp_q[0].data, wb.data);
            assert (wb.is_mask === exp_q[0].is_mask)
                else value_error("wb.is_mask", riscv_v_data_t'(exp_q[0].is_mask),
                                 riscv_v_data_t'(wb.is_mask));
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end else if (due_q.size() != 0) begin
            assert (due_q[0] > cycles)
                else plain_error($sformatf("wb_valid missing at cycle %0d", due_q[0]));
        end
    end

    initial begin
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        add_every_sew();
        sub_every_sew();
        vl_vstart_limits();
        masked_add();
        compare_equal();
        back_to_back();
        repeat (DRAIN_CYCLES) @(negedge clk);
        if (exp_q.size() != 0) begin
            plain_error("Operations still in flight at the end of the run");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule : riscv_v_tb

/* list.f */
hw/riscv_pkg.sv
hw/riscv_v_pkg.sv
hw/riscv_v_decode_element.sv
hw/riscv_v_decode_stage.sv
hw/riscv_v_alu_stage.sv
hw/riscv_v_writeback_stage.sv
hw/riscv_v_top.sv
tests/riscv_v_tb.sv
